/* build.f */
common/gcu_pkg.sv
common/gcu_vram_if.sv
cpu_bus/gcu_bus_ctrl.sv
cpu_bus/gcu_scroll_regs.sv
verilog/gcu_vram.sv
verilog/gcu_video_timing.sv
verilog/gcu_top.sv
test/tb_clock_gen.sv
test/gcu_sva.sv
test/tb_gcu.sv

/* common/gcu_pkg.sv */
`default_nettype none

package gcu_pkg;

    // cpu data word and video ram word
    localparam int DATA_W = 16;
    localparam int VRAM_AW = 13;

    // scroll registers keep the low bits of the written word
    localparam int SCROLL_W = 13;
    localparam int NUM_SCROLL = 8;
    localparam int SCROLL_SEL_W = $clog2(NUM_SCROLL);

    // register number, index bits plus the high flag bit
    localparam int REG_NUM_W = 8;
    localparam logic [REG_NUM_W-1:0] REG_SEL_MASK = 8'h8F;
    localparam logic [REG_NUM_W-1:0] REG_NUM_INIT = 8'hFF;
    localparam logic [REG_NUM_W-1:0] SCROLL_IDX_MASK = 8'h87;

    // beam position
    localparam int POS_W = 9;
    localparam logic [POS_W-1:0] VINT_LINE = 9'hE6;

    // register numbers that acknowledge the vertical interrupt
    localparam logic [REG_NUM_W-1:0] VINT_ACK_REG_A = 8'h0E;
    localparam logic [REG_NUM_W-1:0] VINT_ACK_REG_B = 8'h0F;
    localparam logic [REG_NUM_W-1:0] VINT_ACK_REG_C = 8'h8F;

    // cpu operation strobes
    localparam int NUM_OPS = 6;

    // read sequence length, address to dout
    localparam int RD_WAIT = 3;
    localparam int RD_STEP_W = $clog2(RD_WAIT + 1);

endpackage

`default_nettype wire

/* common/gcu_vram_if.sv */
`timescale 1ns/100ps
`default_nettype none

// cpu side port of the video ram
interface gcu_vram_if import gcu_pkg::*; ();

    logic [VRAM_AW-1:0] addr;
    logic [DATA_W-1:0]  wdata;
    logic               we;
    logic [DATA_W-1:0]  rdata;

    modport cpu (
        output addr,
        output wdata,
        output we,
        input  rdata
    );

    modport mem (
        input  addr,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

`default_nettype wire

/* cpu_bus/gcu_bus_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module gcu_bus_ctrl import gcu_pkg::*; (
    input  wire logic              CLK96,
    input  wire logic              RESET96,
    input  wire logic              op_select_reg,
    input  wire logic              op_write_reg,
    input  wire logic              op_write_ram,
    input  wire logic              op_read_ram_h,
    input  wire logic              op_read_ram_l,
    input  wire logic              op_set_ram_ptr,
    input  wire logic [DATA_W-1:0] din,
    output logic                   ack,
    output logic      [DATA_W-1:0] dout,
    output logic                   sel_wr,
    output logic                   reg_wr,
    gcu_vram_if.cpu                vram
);

    logic [NUM_OPS-1:0]   op_vec;
    logic [NUM_OPS-1:0]   last_op;
    logic                 op_change;
    logic                 rd_op;
    logic [DATA_W-1:0]    ram_ptr;
    logic [RD_STEP_W-1:0] rd_step;
    logic [RD_STEP_W-1:0] rd_step_eff;
    logic                 wr_issued;
    logic                 wr_issued_eff;
    logic                 wr_start;
    logic                 rd_start;
    logic                 rd_wait;
    logic                 rd_load;

    assign op_vec = {op_select_reg, op_write_reg, op_set_ram_ptr,
                     op_write_ram, op_read_ram_h, op_read_ram_l};
    assign op_change = (op_vec != last_op);
    assign rd_op = op_read_ram_h | op_read_ram_l;

    // sequencer state as seen this cycle, restarted by a new operation
    assign rd_step_eff = op_change ? '0 : rd_step;
    assign wr_issued_eff = wr_issued & ~op_change;

    assign wr_start = op_write_ram & ~wr_issued_eff;
    assign rd_start = rd_op & (rd_step_eff == '0);
    assign rd_wait = rd_op & (rd_step_eff != '0) &
                     (rd_step_eff < RD_STEP_W'(RD_WAIT - 1));
    assign rd_load = rd_op & (rd_step_eff == RD_STEP_W'(RD_WAIT - 1));

    // register strobes fire on the first cycle of the operation only
    assign sel_wr = op_select_reg & op_change;
    assign reg_wr = op_write_reg & op_change;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            last_op <= '0;
            ram_ptr <= '0;
            rd_step <= '0;
            wr_issued <= 1'b0;
            ack <= 1'b1;
            vram.we <= 1'b0;
        end else begin
            last_op <= op_vec;
            vram.we <= wr_start;
            // ack low while a ram access is in flight
            ack <= ~(wr_start | rd_start | rd_wait);
            if (op_set_ram_ptr) begin
                ram_ptr <= din;
            end else if (op_write_ram) begin
                wr_issued <= 1'b1;
                // second cycle of the write, step to the next word
                if (wr_issued_eff && vram.we) begin
                    ram_ptr <= ram_ptr + 1'b1;
                end
            end else if (rd_op) begin
                if (rd_step_eff < RD_STEP_W'(RD_WAIT)) begin
                    rd_step <= rd_step_eff + 1'b1;
                end
            end else begin
                wr_issued <= 1'b0;
                rd_step <= '0;
            end
        end
    end

    // ram address, write data and read result
    always_ff @(posedge CLK96) begin
        if (wr_start) begin
            vram.addr <= ram_ptr[VRAM_AW-1:0];
            vram.wdata <= din;
        end else if (rd_start) begin
            // low read takes the word after the pointer
            vram.addr <= ram_ptr[VRAM_AW-1:0] + VRAM_AW'(op_read_ram_l);
        end
        if (rd_load) begin
            dout <= vram.rdata;
        end
    end

endmodule

`default_nettype wire

/* cpu_bus/gcu_scroll_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module gcu_scroll_regs import gcu_pkg::*; (
    input  wire logic                 CLK96,
    input  wire logic                 RESET96,
    input  wire logic                 sel_wr,
    input  wire logic                 reg_wr,
    input  wire logic [DATA_W-1:0]    din,
    output logic      [REG_NUM_W-1:0] reg_num,
    output logic      [SCROLL_W-1:0]  bg_scroll_x,
    output logic      [SCROLL_W-1:0]  bg_scroll_y,
    output logic      [SCROLL_W-1:0]  fg_scroll_x,
    output logic      [SCROLL_W-1:0]  fg_scroll_y,
    output logic      [SCROLL_W-1:0]  txt_scroll_x,
    output logic      [SCROLL_W-1:0]  txt_scroll_y,
    output logic      [SCROLL_W-1:0]  spr_scroll_x,
    output logic      [SCROLL_W-1:0]  spr_scroll_y
);

    logic [SCROLL_W-1:0]     scroll [NUM_SCROLL];
    logic                    scroll_hit;
    logic [SCROLL_SEL_W-1:0] scroll_idx;

    // only 0-7 and 0x80-0x87 address a scroll register
    assign scroll_hit = ((reg_num & ~SCROLL_IDX_MASK) == '0);
    assign scroll_idx = reg_num[SCROLL_SEL_W-1:0];

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            reg_num <= REG_NUM_INIT;
        end else if (sel_wr) begin
            reg_num <= din[REG_NUM_W-1:0] & REG_SEL_MASK;
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            for (int i = 0; i < NUM_SCROLL; i++) begin
                scroll[i] <= '0;
            end
        end else if (reg_wr && scroll_hit) begin
            scroll[scroll_idx] <= din[SCROLL_W-1:0];
        end
    end

    // x and y pairs per layer
    assign bg_scroll_x  = scroll[0];
    assign bg_scroll_y  = scroll[1];
    assign fg_scroll_x  = scroll[2];
    assign fg_scroll_y  = scroll[3];
    assign txt_scroll_x = scroll[4];
    assign txt_scroll_y = scroll[5];
    assign spr_scroll_x = scroll[6];
    assign spr_scroll_y = scroll[7];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert --top-module tb_gcu -f build.f \
    -Mdir obj_dir -o tb_gcu_sim > "$LOG" 2>&1 \
    && ./obj_dir/tb_gcu_sim >> "$LOG" 2>&1 \
    || echo "build or simulation returned an error" >> "$LOG"
cat "$LOG"
grep -q "Simulation failed" "$LOG" && { echo "RESULT: FAIL"; exit 1; }
grep -q "Simulation completed successfully" "$LOG" || { echo "RESULT: FAIL"; exit 1; }
echo "RESULT: PASS"
exit 0

/* test/gcu_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module gcu_sva import gcu_pkg::*; (
    input wire logic CLK96,
    input wire logic RESET96,
    input wire logic op_write_ram,
    input wire logic op_read_ram_h,
    input wire logic op_read_ram_l,
    input wire logic ack,
    input wire logic we
);

    logic rd_op;

    assign rd_op = op_read_ram_h | op_read_ram_l;

    // one write strobe per ram write
    we_single: assert property (@(posedge CLK96) disable iff (RESET96)
        $rose(op_write_ram) |=> we ##1 !we)
        else $error("ram write did not give a single cycle write strobe");

    ack_write: assert property (@(posedge CLK96) disable iff (RESET96)
        $rose(op_write_ram) |=> !ack ##1 ack)
        else $error("ack not low for exactly one cycle on a ram write");

    // address, wait, load
    ack_read: assert property (@(posedge CLK96) disable iff (RESET96)
        $rose(rd_op) |-> ##RD_WAIT $rose(ack))
        else $error("ack did not rise at the end of the read sequence");

endmodule

bind gcu_bus_ctrl gcu_sva sva0 (
    .CLK96         (CLK96),
    .RESET96       (RESET96),
    .op_write_ram  (op_write_ram),
    .op_read_ram_h (op_read_ram_h),
    .op_read_ram_l (op_read_ram_l),
    .ack           (ack),
    .we            (vram.we)
);

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic CLK96,
    output logic RESET96
);

    // 8 ns period
    initial begin
        CLK96 = 1'b0;
        forever #4 CLK96 = ~CLK96;
    end

    // reset held over the first 16 rising edges
    initial begin
        RESET96 <= 1'b1;
        repeat (16) @(posedge CLK96);
        RESET96 <= 1'b0;
    end

endmodule

`default_nettype wire

/* test/tb_gcu.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_gcu import gcu_pkg::*; ();

    logic                 CLK96;
    logic                 RESET96;
    logic                 op_select_reg;
    logic                 op_write_reg;
    logic                 op_write_ram;
    logic                 op_read_ram_h;
    logic                 op_read_ram_l;
    logic                 op_set_ram_ptr;
    logic [DATA_W-1:0]    din;
    logic [POS_W-1:0]     h;
    logic [POS_W-1:0]     v;
    logic [POS_W-1:0]     hs_start;
    logic [POS_W-1:0]     hs_end;
    logic [POS_W-1:0]     vs_start;
    logic [POS_W-1:0]     vs_end;
    logic [VRAM_AW-1:0]   render_addr;
    logic                 ack;
    logic [DATA_W-1:0]    dout;
    logic                 vint;
    logic                 hsync;
    logic                 vsync;
    logic                 fblank;
    logic [SCROLL_W-1:0]  bg_scroll_x;
    logic [SCROLL_W-1:0]  bg_scroll_y;
    logic [SCROLL_W-1:0]  fg_scroll_x;
    logic [SCROLL_W-1:0]  fg_scroll_y;
    logic [SCROLL_W-1:0]  txt_scroll_x;
    logic [SCROLL_W-1:0]  txt_scroll_y;
    logic [SCROLL_W-1:0]  spr_scroll_x;
    logic [SCROLL_W-1:0]  spr_scroll_y;
    logic [DATA_W-1:0]    render_data;

    // expected state of the DUT
    integer               seed = 32'h0a93_a2f8;
    logic [REG_NUM_W-1:0] exp_reg;
    logic [DATA_W-1:0]    exp_ptr;
    logic [SCROLL_W-1:0]  exp_scroll [NUM_SCROLL];
    logic [DATA_W-1:0]    vram_model [2**VRAM_AW];

    tb_clock_gen clk_gen0 (
        .CLK96   (CLK96),
        .RESET96 (RESET96)
    );

    gcu_top dut0 (.*);

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // op bits in order select, write reg, set ptr, write ram, read high, read low
    task automatic run_op(input logic [5:0] ops, input logic [DATA_W-1:0] data);
        int cycles;
        int exp_low;
        exp_low = 0;
        if (ops[2]) begin
            // a ram write holds ack low for one cycle
            exp_low = 1;
        end else if (ops[1] || ops[0]) begin
            // address and wait cycles of a read
            exp_low = RD_WAIT - 1;
        end
        @(posedge CLK96);
        {op_select_reg, op_write_reg, op_set_ram_ptr,
         op_write_ram, op_read_ram_h, op_read_ram_l} <= ops;
        din <= data;
        @(posedge CLK96);
        cycles = 0;
        @(negedge CLK96);
        while (!ack) begin
            if (cycles == 20) begin
                $display("timeout while waiting for ack from the DUT");
                $display("Simulation failed");
                $fatal(1, "ack timeout");
            end else begin
                cycles++;
                @(negedge CLK96);
            end
        end
        check_value("ack low cycles", 32'(cycles), 32'(exp_low));
        @(posedge CLK96);
        {op_select_reg, op_write_reg, op_set_ram_ptr,
         op_write_ram, op_read_ram_h, op_read_ram_l} <= 6'b000000;
    endtask

    task automatic check_scrolls();
        check_value("bg_scroll_x", 32'(bg_scroll_x), 32'(exp_scroll[0]));
        check_value("bg_scroll_y", 32'(bg_scroll_y), 32'(exp_scroll[1]));
        check_value("fg_scroll_x", 32'(fg_scroll_x), 32'(exp_scroll[2]));
        check_value("fg_scroll_y", 32'(fg_scroll_y), 32'(exp_scroll[3]));
        check_value("txt_scroll_x", 32'(txt_scroll_x), 32'(exp_scroll[4]));
        check_value("txt_scroll_y", 32'(txt_scroll_y), 32'(exp_scroll[5]));
        check_value("spr_scroll_x", 32'(spr_scroll_x), 32'(exp_scroll[6]));
        check_value("spr_scroll_y", 32'(spr_scroll_y), 32'(exp_scroll[7]));
    endtask

    task automatic select_reg(input logic [DATA_W-1:0] word);
        run_op(6'b100000, word);
        exp_reg = word[REG_NUM_W-1:0] & REG_SEL_MASK;
    endtask

    task automatic write_reg(input logic [DATA_W-1:0] word);
        run_op(6'b010000, word);
        // scroll registers sit at 0-7 and 0x80-0x87
        if (exp_reg <= 8'h07 || (exp_reg >= 8'h80 && exp_reg <= 8'h87)) begin
            exp_scroll[exp_reg[2:0]] = word[SCROLL_W-1:0];
        end
        check_scrolls();
    endtask

    task automatic set_ptr(input logic [DATA_W-1:0] word);
        run_op(6'b001000, word);
        exp_ptr = word;
    endtask

    task automatic write_ram(input logic [DATA_W-1:0] word);
        run_op(6'b000100, word);
        vram_model[VRAM_AW'(exp_ptr)] = word;
        exp_ptr = exp_ptr + 16'd1;
    endtask

    task automatic read_ram(input logic low);
        run_op(low ? 6'b000001 : 6'b000010, 16'h0000);
        check_value("dout", 32'(dout),
                    32'(vram_model[VRAM_AW'(exp_ptr + DATA_W'(low))]));
    endtask

    task automatic check_render(input logic [VRAM_AW-1:0] addr);
        logic [VRAM_AW-1:0] prev_addr;
        @(posedge CLK96);
        prev_addr = render_addr;
        render_addr <= addr;
        @(negedge CLK96);
        // renderer port still shows the word of the old address
        check_value("render_data", 32'(render_data), 32'(vram_model[prev_addr]));
        @(posedge CLK96);
        @(negedge CLK96);
        check_value("render_data", 32'(render_data), 32'(vram_model[addr]));
    endtask

    function automatic logic vint_expected(input logic [POS_W-1:0] vy,
                                           input logic [REG_NUM_W-1:0] num);
        return !(vy == VINT_LINE || num == VINT_ACK_REG_A ||
                 num == VINT_ACK_REG_B || num == VINT_ACK_REG_C);
    endfunction

    // syncs are active low and blank is low when either sync is low
    task automatic check_sync(input logic [POS_W-1:0] hx, input logic [POS_W-1:0] vy);
        logic exp_hs;
        logic exp_vs;
        @(posedge CLK96);
        h <= hx;
        v <= vy;
        @(negedge CLK96);
        exp_hs = !(hx > hs_start && hx < hs_end);
        exp_vs = !(vy >= vs_start && vy <= vs_end);
        check_value("hsync", 32'(hsync), 32'(exp_hs));
        check_value("vsync", 32'(vsync), 32'(exp_vs));
        check_value("fblank", 32'(fblank), 32'(!(!exp_hs || !exp_vs)));
        check_value("vint", 32'(vint), 32'(vint_expected(vy, exp_reg)));
    endtask

    task automatic test_reset();
        check_value("ack", 32'(ack), 32'd1);
        check_scrolls();
        check_value("vint", 32'(vint), 32'(vint_expected(v, exp_reg)));
    endtask

    task automatic test_scroll();
        for (int i = 0; i < NUM_SCROLL; i++) begin
            select_reg(16'hA500 | 16'(i));
            write_reg(DATA_W'($random(seed)));
            // bits 6:4 are masked away and the flag bit stays
            select_reg(16'h00F0 | 16'(i));
            write_reg(DATA_W'($random(seed)));
        end
        select_reg(16'h000E);
        write_reg(DATA_W'($random(seed)));
        select_reg(16'h0088);
        write_reg(DATA_W'($random(seed)));
    endtask

    task automatic test_vram();
        set_ptr(16'h0100);
        for (int i = 0; i < 12; i++) begin
            write_ram(DATA_W'($random(seed)));
        end
        for (int i = 0; i < 12; i++) begin
            set_ptr(DATA_W'(16'h0100 + i));
            read_ram(1'b0);
        end
        for (int i = 0; i < 11; i++) begin
            set_ptr(DATA_W'(16'h0100 + i));
            read_ram(1'b1);
        end
        // pointer beyond 8K wraps so words land at 0x1FFE..0x0001
        set_ptr(16'h3FFE);
        for (int i = 0; i < 4; i++) begin
            write_ram(DATA_W'($random(seed)));
        end
        for (int i = 0; i < 4; i++) begin
            set_ptr(DATA_W'(16'h3FFE + i));
            read_ram(1'b0);
        end
        set_ptr(16'h3FFF);
        read_ram(1'b1);
        set_ptr(16'h1FFF);
        read_ram(1'b1);
    endtask

    task automatic test_render();
        for (int i = 0; i < 12; i++) begin
            check_render(VRAM_AW'(16'h0100 + i));
        end
        for (int i = 0; i < 4; i++) begin
            check_render(VRAM_AW'(16'h3FFE + i));
        end
    endtask

    task automatic test_vint();
        select_reg(16'h0003);
        check_sync(9'd0, 9'd0);
        check_sync(9'd0, VINT_LINE);
        check_sync(9'd0, 9'd0);
        select_reg(16'h000E);
        check_sync(9'd0, 9'd0);
        select_reg(16'h0005);
        check_sync(9'd0, 9'd0);
        select_reg(16'h000F);
        check_sync(9'd0, 9'd0);
        select_reg(16'h0003);
        check_sync(9'd0, 9'd0);
        select_reg(16'h008F);
        check_sync(9'd0, 9'd0);
        select_reg(16'h001F);
        check_sync(9'd0, 9'd0);
        select_reg(16'h008E);
        check_sync(9'd0, 9'd0);
    endtask

    task automatic test_sync();
        for (int i = 0; i < 32; i++) begin
            check_sync(POS_W'(i), 9'd50);
        end
        for (int i = 96; i < 112; i++) begin
            check_sync(9'd5, POS_W'(i));
            check_sync(9'd15, POS_W'(i));
        end
    endtask

    initial begin
        int cycles;
        op_select_reg <= 1'b0;
        op_write_reg <= 1'b0;
        op_write_ram <= 1'b0;
        op_read_ram_h <= 1'b0;
        op_read_ram_l <= 1'b0;
        op_set_ram_ptr <= 1'b0;
        din <= '0;
        h <= '0;
        v <= '0;
        hs_start <= 9'd10;
        hs_end <= 9'd20;
        vs_start <= 9'd100;
        vs_end <= 9'd108;
        render_addr <= '0;
        exp_reg = 8'hFF;
        exp_ptr = '0;
        for (int i = 0; i < NUM_SCROLL; i++) begin
            exp_scroll[i] = '0;
        end
        cycles = 0;
        @(negedge CLK96);
        // interrupt is held off during reset
        check_value("vint", 32'(vint), 32'd0);
        while (RESET96) begin
            if (cycles == 64) begin
                $display("timeout while waiting for reset to be released");
                $display("Simulation failed");
                $fatal(1, "reset timeout");
            end else begin
                cycles++;
                @(negedge CLK96);
            end
        end
        test_reset();
        test_scroll();
        test_vram();
        test_render();
        test_vint();
        test_sync();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/gcu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module gcu_top import gcu_pkg::*; (
    input  wire logic                CLK96,
    input  wire logic                RESET96,
    input  wire logic                op_select_reg,
    input  wire logic                op_write_reg,
    input  wire logic                op_write_ram,
    input  wire logic                op_read_ram_h,
    input  wire logic                op_read_ram_l,
    input  wire logic                op_set_ram_ptr,
    input  wire logic [DATA_W-1:0]   din,
    input  wire logic [POS_W-1:0]    h,
    input  wire logic [POS_W-1:0]    v,
    input  wire logic [POS_W-1:0]    hs_start,
    input  wire logic [POS_W-1:0]    hs_end,
    input  wire logic [POS_W-1:0]    vs_start,
    input  wire logic [POS_W-1:0]    vs_end,
    input  wire logic [VRAM_AW-1:0]  render_addr,
    output logic                     ack,
    output logic      [DATA_W-1:0]   dout,
    output logic                     vint,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     fblank,
    output logic      [SCROLL_W-1:0] bg_scroll_x,
    output logic      [SCROLL_W-1:0] bg_scroll_y,
    output logic      [SCROLL_W-1:0] fg_scroll_x,
    output logic      [SCROLL_W-1:0] fg_scroll_y,
    output logic      [SCROLL_W-1:0] txt_scroll_x,
    output logic      [SCROLL_W-1:0] txt_scroll_y,
    output logic      [SCROLL_W-1:0] spr_scroll_x,
    output logic      [SCROLL_W-1:0] spr_scroll_y,
    output logic      [DATA_W-1:0]   render_data
);

    wire                 sel_wr;
    wire                 reg_wr;
    wire [REG_NUM_W-1:0] reg_num;

    gcu_vram_if vram_if ();

    gcu_bus_ctrl bus_ctrl0 (
        .CLK96          (CLK96),
        .RESET96        (RESET96),
        .op_select_reg  (op_select_reg),
        .op_write_reg   (op_write_reg),
        .op_write_ram   (op_write_ram),
        .op_read_ram_h  (op_read_ram_h),
        .op_read_ram_l  (op_read_ram_l),
        .op_set_ram_ptr (op_set_ram_ptr),
        .din            (din),
        .ack            (ack),
        .dout           (dout),
        .sel_wr         (sel_wr),
        .reg_wr         (reg_wr),
        .vram           (vram_if.cpu)
    );

    gcu_scroll_regs scroll_regs0 (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .sel_wr       (sel_wr),
        .reg_wr       (reg_wr),
        .din          (din),
        .reg_num      (reg_num),
        .bg_scroll_x  (bg_scroll_x),
        .bg_scroll_y  (bg_scroll_y),
        .fg_scroll_x  (fg_scroll_x),
        .fg_scroll_y  (fg_scroll_y),
        .txt_scroll_x (txt_scroll_x),
        .txt_scroll_y (txt_scroll_y),
        .spr_scroll_x (spr_scroll_x),
        .spr_scroll_y (spr_scroll_y)
    );

    gcu_vram vram0 (
        .CLK96       (CLK96),
        .cpu         (vram_if.mem),
        .render_addr (render_addr),
        .render_data (render_data)
    );

    gcu_video_timing video_timing0 (
        .RESET96  (RESET96),
        .h        (h),
        .v        (v),
        .hs_start (hs_start),
        .hs_end   (hs_end),
        .vs_start (vs_start),
        .vs_end   (vs_end),
        .reg_num  (reg_num),
        .hsync    (hsync),
        .vsync    (vsync),
        .fblank   (fblank),
        .vint     (vint)
    );

endmodule

`default_nettype wire

/* verilog/gcu_video_timing.sv */
`timescale 1ns/100ps
`default_nettype none

module gcu_video_timing import gcu_pkg::*; (
    input  wire logic                 RESET96,
    input  wire logic [POS_W-1:0]     h,
    input  wire logic [POS_W-1:0]     v,
    input  wire logic [POS_W-1:0]     hs_start,
    input  wire logic [POS_W-1:0]     hs_end,
    input  wire logic [POS_W-1:0]     vs_start,
    input  wire logic [POS_W-1:0]     vs_end,
    input  wire logic [REG_NUM_W-1:0] reg_num,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      fblank,
    output logic                      vint
);

    logic vint_ack;

    // syncs are active low
    assign hsync = ~((h > hs_start) && (h < hs_end));
    assign vsync = ~((v >= vs_start) && (v <= vs_end));
    assign fblank = hsync & vsync;

    // cpu clears the interrupt by selecting one of these registers
    assign vint_ack = (reg_num == VINT_ACK_REG_A) ||
                      (reg_num == VINT_ACK_REG_B) ||
                      (reg_num == VINT_ACK_REG_C);

    assign vint = ~(RESET96 || (v == VINT_LINE) || vint_ack);

endmodule

`default_nettype wire

/* verilog/gcu_vram.sv */
`timescale 1ns/100ps
`default_nettype none

module gcu_vram import gcu_pkg::*; (
    input  wire logic               CLK96,
    gcu_vram_if.mem                 cpu,
    input  wire logic [VRAM_AW-1:0] render_addr,
    output logic      [DATA_W-1:0]  render_data
);

    logic [DATA_W-1:0] mem [2**VRAM_AW];

    // cpu port, read returns the old word on a collision
    always_ff @(posedge CLK96) begin
        if (cpu.we) begin
            mem[cpu.addr] <= cpu.wdata;
        end
        cpu.rdata <= mem[cpu.addr];
    end

    // renderer port is read only
    always_ff @(posedge CLK96) begin
        render_data <= mem[render_addr];
    end

endmodule

`default_nettype wire
